// File: tb.f
+incdir+include
rtl/game_pkg.sv
rtl/vga_timing.sv
rtl/draw_background.sv
rtl/player_regs.sv
rtl/draw_player.sv
rtl/game_top.sv
bench/game_checker.sv
bench/tb_game.sv

// File: bench/tb_game.sv
`timescale 1ns/1ns

`include "game_params.svh"

module tb_game;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int CYCLE_LIMIT  = 6 * FRAME_CYCLES + 2000;

    logic                clk;
    logic                rst;
    game_pkg::axil_req_t axi_req;
    game_pkg::axil_rsp_t axi_rsp;
    game_pkg::vga_bus_t  vga_out;
    int                  pix_errs;
    int                  sync_errs;
    int                  bus_errs;
    logic [15:0]         lfsr;
    int                  cycle_count;

    game_top UUT (
        .clk     (clk),
        .rst     (rst),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp),
        .vga_out (vga_out)
    );

    game_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .axi_req   (axi_req),
        .axi_rsp   (axi_rsp),
        .vga_out   (vga_out),
        .pix_errs  (pix_errs),
        .sync_errs (sync_errs),
        .bus_errs  (bus_errs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int hold);
        axi_req.awaddr  <= addr;
        axi_req.wdata   <= data;
        axi_req.wstrb   <= 4'hF;
        axi_req.awvalid <= 1'b1;
        axi_req.wvalid  <= 1'b1;
        do @(posedge clk); while (!axi_rsp.awready);
        axi_req.awvalid <= 1'b0;
        axi_req.wvalid  <= 1'b0;
        do @(posedge clk); while (!axi_rsp.bvalid);
        if (hold > 0) begin
            // a second write offered now must not be taken
            axi_req.awvalid <= 1'b1;
            axi_req.wvalid  <= 1'b1;
            repeat (hold) @(posedge clk);
            axi_req.awvalid <= 1'b0;
            axi_req.wvalid  <= 1'b0;
        end
        axi_req.bready <= 1'b1;
        @(posedge clk);
        axi_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input int hold);
        axi_req.araddr  <= addr;
        axi_req.arvalid <= 1'b1;
        do @(posedge clk); while (!axi_rsp.arready);
        axi_req.arvalid <= 1'b0;
        do @(posedge clk); while (!axi_rsp.rvalid);
        if (hold > 0) begin
            axi_req.arvalid <= 1'b1;
            repeat (hold) @(posedge clk);
            axi_req.arvalid <= 1'b0;
        end
        axi_req.rready <= 1'b1;
        @(posedge clk);
        axi_req.rready <= 1'b0;
    endtask

    // returns on the last pixel of a frame
    task automatic next_frame;
        do @(posedge clk);
        while (!(vga_out.hcount == 12'(`H_TOTAL - 1) && vga_out.vcount == 12'(`V_TOTAL - 1)));
    endtask

    // random position and colors, junk in the unused upper bits
    task automatic place_player(input logic [1:0] state);
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] c;
        logic [31:0] pad;
        take_bits(9, x);
        take_bits(7, y);
        take_bits(24, c);
        take_bits(20, pad);
        axi_write(`REG_STATE, {pad[19:0], 10'd0, state}, 0);
        axi_write(`REG_XPOS, {pad[19:0], 12'(x + 32)}, 0);
        axi_write(`REG_YPOS, {pad[19:0], y[11:0]}, 0);
        axi_write(`REG_COLOR, {pad[7:0], c[23:0]}, 0);
    endtask

    task automatic finish_run(input logic timed_out);
        $display("errors: pixel %0d, sync %0d, bus %0d", pix_errs, sync_errs, bus_errs);
        if (timed_out || (pix_errs + sync_errs + bus_errs) != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    endtask

    initial begin
        rst     = 1'b1;
        axi_req = '0;
        lfsr    = 16'd9;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // default idle frame
        next_frame();
        next_frame();
        place_player(game_pkg::RIGHT);
        next_frame();
        place_player(game_pkg::LEFT);
        next_frame();
        axi_read(`REG_STATE, 0);
        axi_read(`REG_XPOS, 0);
        axi_read(`REG_YPOS, 0);
        axi_read(`REG_COLOR, 0);
        // rejected accesses leave the picture alone
        axi_write(`REG_STATE, 32'hFFFF_FFF3, 0);
        axi_write(4'h2, 32'h0000_0123, 0);
        axi_read(4'h6, 0);
        axi_read(`REG_STATE, 0);
        next_frame();
        axi_write(`REG_XPOS, 32'd200, 5);
        axi_read(`REG_XPOS, 5);
        repeat (8) @(posedge clk);
        finish_run(1'b0);
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: test sequence still running after %0d cycles", cycle_count);
        finish_run(1'b1);
    end

endmodule

// File: bench/game_checker.sv
`timescale 1ns/1ns

`include "game_params.svh"

module game_checker (
    input  logic                clk,
    input  logic                rst,
    input  game_pkg::axil_req_t axi_req,
    input  game_pkg::axil_rsp_t axi_rsp,
    input  game_pkg::vga_bus_t  vga_out,
    output int                  pix_errs,
    output int                  sync_errs,
    output int                  bus_errs
);

    localparam int H_SYNC_START = `H_ACTIVE + `H_FP;
    localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FP;
    localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;

    game_pkg::player_cfg_t shadow;
    logic        b_pend;
    logic        r_pend;
    logic [1:0]  exp_bresp;
    logic [1:0]  exp_rresp;
    logic [31:0] exp_rdata;
    int          skip;
    int          settle;
    int          rst_edges;
    logic [11:0] prev_h;
    logic [11:0] prev_v;
    logic        prev_valid;
    logic        prev_hs;
    logic        prev_vs;
    logic        hs_seen;
    logic        vs_seen;
    int          hs_gap;
    int          vs_gap;

    initial begin
        pix_errs  = 0;
        sync_errs = 0;
        bus_errs  = 0;
        rst_edges = 0;
    end

    function automatic logic between(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    // expected pixel color from the background and sprite rules
    function automatic logic [11:0] pixel_color(input logic [11:0] h, input logic [11:0] v,
            input logic hblnk, input logic vblnk, input game_pkg::player_cfg_t c);
        int          col;
        int          row;
        int          dl;
        int          dr;
        logic        eye;
        logic        body;
        logic [11:0] bg;
        if (hblnk || vblnk) begin
            return 12'h000;
        end
        bg  = (v < `GROUND_Y) ? `SKY_RGB : `GROUND_RGB;
        col = int'(h) - int'(c.xpos);
        // larger ypos lifts the sprite
        row = int'(v) + int'($signed(c.ypos));
        dl  = (col - `EYE_L_COL) * (col - `EYE_L_COL) + (row - `EYE_ROW) * (row - `EYE_ROW);
        dr  = (col - `EYE_R_COL) * (col - `EYE_R_COL) + (row - `EYE_ROW) * (row - `EYE_ROW);
        eye  = 1'b0;
        body = 1'b0;
        case (c.state)
            game_pkg::IDLE: begin
                eye  = (dl <= `EYE_R2) || (dr <= `EYE_R2);
                body = (between(col, 1, 39) && between(row, 421, 480))
                    || ((between(col, 1, 14) || between(col, 26, 39))
                        && (between(row, `SPR_TOP, 420) || between(row, 481, `SPR_BOTTOM - 1)));
            end
            game_pkg::RIGHT: begin
                body = between(col, 1, 24) && between(row, `SPR_TOP + 1, `SPR_BOTTOM - 1);
                eye  = between(col, 25, 29) && between(row, 431, 449);
            end
            game_pkg::LEFT: begin
                body = between(col, 6, 29) && between(row, `SPR_TOP + 1, `SPR_BOTTOM - 1);
                eye  = between(col, 0, 4) && between(row, 431, 449);
            end
            default: ;
        endcase
        if (eye) begin
            return c.eye_rgb;
        end else if (body) begin
            return c.body_rgb;
        end
        return bg;
    endfunction

    task report_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
        $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    task check_bus;
        if (axi_rsp.bvalid !== b_pend) begin
            bus_errs++;
            report_value("axi_rsp.bvalid", b_pend, axi_rsp.bvalid);
        end else if (b_pend && axi_rsp.bresp !== exp_bresp) begin
            bus_errs++;
            report_value("axi_rsp.bresp", exp_bresp, axi_rsp.bresp);
        end
        if (axi_rsp.rvalid !== r_pend) begin
            bus_errs++;
            report_value("axi_rsp.rvalid", r_pend, axi_rsp.rvalid);
        end else if (r_pend) begin
            // data must hold steady until rready
            if (axi_rsp.rdata !== exp_rdata) begin
                bus_errs++;
                report_value("axi_rsp.rdata", exp_rdata, axi_rsp.rdata);
            end
            if (axi_rsp.rresp !== exp_rresp) begin
                bus_errs++;
                report_value("axi_rsp.rresp", exp_rresp, axi_rsp.rresp);
            end
        end
        if (axi_rsp.awready !== axi_rsp.wready) begin
            bus_errs++;
            report_value("axi_rsp.wready", axi_rsp.awready, axi_rsp.wready);
        end
        if (axi_rsp.awready && b_pend) begin
            bus_errs++;
            $display("write accepted at %0t while a write response was pending", $time);
        end
        if (axi_rsp.arready && r_pend) begin
            bus_errs++;
            $display("read accepted at %0t while a read response was pending", $time);
        end
        if (b_pend && axi_rsp.bvalid && axi_req.bready) begin
            b_pend = 1'b0;
        end
        if (r_pend && axi_rsp.rvalid && axi_req.rready) begin
            r_pend = 1'b0;
        end
        // read sees the registers before a write on the same edge
        if (axi_req.arvalid && axi_rsp.arready) begin
            exp_rresp = `RESP_OKAY;
            exp_rdata = '0;
            case (axi_req.araddr)
                `REG_STATE: exp_rdata = {30'd0, shadow.state};
                `REG_XPOS:  exp_rdata = {20'd0, shadow.xpos};
                `REG_YPOS:  exp_rdata = {20'd0, shadow.ypos};
                `REG_COLOR: exp_rdata = {8'd0, shadow.eye_rgb, shadow.body_rgb};
                default:    exp_rresp = `RESP_SLVERR;
            endcase
            r_pend = 1'b1;
        end
        if (axi_req.awvalid && axi_req.wvalid && axi_rsp.awready) begin
            exp_bresp = `RESP_OKAY;
            case (axi_req.awaddr)
                `REG_STATE: begin
                    if (axi_req.wdata[1:0] == 2'd3) begin
                        exp_bresp = `RESP_SLVERR;
                    end else begin
                        shadow.state = game_pkg::player_state_t'(axi_req.wdata[1:0]);
                    end
                end
                `REG_XPOS: shadow.xpos = axi_req.wdata[11:0];
                `REG_YPOS: shadow.ypos = axi_req.wdata[11:0];
                `REG_COLOR: begin
                    shadow.body_rgb = axi_req.wdata[11:0];
                    shadow.eye_rgb  = axi_req.wdata[23:12];
                end
                default: exp_bresp = `RESP_SLVERR;
            endcase
            // pixels in flight still carry the old settings
            if (exp_bresp == `RESP_OKAY) begin
                skip = 4;
            end
            b_pend = 1'b1;
        end
    endtask

    task check_video;
        logic [11:0] exp_h;
        logic [11:0] exp_v;
        logic [11:0] exp_rgb;
        logic        exp_hs;
        logic        exp_vs;
        logic        exp_hb;
        logic        exp_vb;
        if (settle > 0) begin
            settle--;
            return;
        end
        exp_hs = (vga_out.hcount >= H_SYNC_START) && (vga_out.hcount < H_SYNC_END);
        exp_vs = (vga_out.vcount >= V_SYNC_START) && (vga_out.vcount < V_SYNC_END);
        exp_hb = (vga_out.hcount >= `H_ACTIVE);
        exp_vb = (vga_out.vcount >= `V_ACTIVE);
        if (vga_out.hsync !== exp_hs) begin
            sync_errs++;
            report_value("vga_out.hsync", exp_hs, vga_out.hsync);
        end
        if (vga_out.vsync !== exp_vs) begin
            sync_errs++;
            report_value("vga_out.vsync", exp_vs, vga_out.vsync);
        end
        if (vga_out.hblnk !== exp_hb) begin
            sync_errs++;
            report_value("vga_out.hblnk", exp_hb, vga_out.hblnk);
        end
        if (vga_out.vblnk !== exp_vb) begin
            sync_errs++;
            report_value("vga_out.vblnk", exp_vb, vga_out.vblnk);
        end
        if (prev_valid) begin
            exp_h = (prev_h == `H_TOTAL - 1) ? 12'd0 : prev_h + 12'd1;
            exp_v = prev_v;
            if (prev_h == `H_TOTAL - 1) begin
                exp_v = (prev_v == `V_TOTAL - 1) ? 12'd0 : prev_v + 12'd1;
            end
            if (vga_out.hcount !== exp_h) begin
                sync_errs++;
                report_value("vga_out.hcount", exp_h, vga_out.hcount);
            end
            if (vga_out.vcount !== exp_v) begin
                sync_errs++;
                report_value("vga_out.vcount", exp_v, vga_out.vcount);
            end
        end
        hs_gap++;
        vs_gap++;
        if (vga_out.hsync && !prev_hs) begin
            if (hs_seen && hs_gap != `H_TOTAL) begin
                sync_errs++;
                $display("hsync period at %0t was %0d cycles, not %0d", $time, hs_gap, `H_TOTAL);
            end
            hs_seen = 1'b1;
            hs_gap  = 0;
        end
        if (vga_out.vsync && !prev_vs) begin
            if (vs_seen && vs_gap != `H_TOTAL * `V_TOTAL) begin
                sync_errs++;
                $display("vsync period at %0t was %0d cycles, not %0d", $time, vs_gap,
                    `H_TOTAL * `V_TOTAL);
            end
            vs_seen = 1'b1;
            vs_gap  = 0;
        end
        prev_h     = vga_out.hcount;
        prev_v     = vga_out.vcount;
        prev_hs    = vga_out.hsync;
        prev_vs    = vga_out.vsync;
        prev_valid = 1'b1;
        if (skip > 0) begin
            skip--;
        end else begin
            exp_rgb = pixel_color(vga_out.hcount, vga_out.vcount, vga_out.hblnk, vga_out.vblnk,
                shadow);
            if (vga_out.rgb !== exp_rgb) begin
                pix_errs++;
                report_value("vga_out.rgb", exp_rgb, vga_out.rgb);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            rst_edges++;
            if (rst_edges > 1) begin
                if (vga_out.hsync !== 1'b0 || vga_out.vsync !== 1'b0 || vga_out.rgb !== 12'h000) begin
                    sync_errs++;
                    $display("video outputs not idle during reset at %0t", $time);
                end
                if ({axi_rsp.bvalid, axi_rsp.rvalid, axi_rsp.awready, axi_rsp.wready,
                        axi_rsp.arready} !== 5'b0) begin
                    bus_errs++;
                    $display("bus handshake outputs not low during reset at %0t", $time);
                end
            end
            shadow.state    = game_pkg::IDLE;
            shadow.xpos     = 12'd300;
            shadow.ypos     = '0;
            shadow.body_rgb = `BODY_RGB_RST;
            shadow.eye_rgb  = `EYE_RGB_RST;
            b_pend     = 1'b0;
            r_pend     = 1'b0;
            skip       = 0;
            settle     = 8;
            prev_valid = 1'b0;
            prev_hs    = 1'b1;
            prev_vs    = 1'b1;
            hs_seen    = 1'b0;
            vs_seen    = 1'b0;
            hs_gap     = 0;
            vs_gap     = 0;
        end else begin
            check_bus();
            check_video();
        end
    end

endmodule

// File: rtl/game_top.sv
`timescale 1ns/1ns

module game_top (
    input  logic                clk,
    input  logic                rst,
    input  game_pkg::axil_req_t axi_req,
    output game_pkg::axil_rsp_t axi_rsp,
    output game_pkg::vga_bus_t  vga_out
);

    game_pkg::vga_bus_t    bus_timing;
    game_pkg::vga_bus_t    bus_bg;
    game_pkg::player_cfg_t player_cfg;

    vga_timing u_vga_timing (
        .clk  (clk),
        .rst  (rst),
        .vout (bus_timing)
    );

    draw_background u_draw_background (
        .clk  (clk),
        .rst  (rst),
        .vin  (bus_timing),
        .vout (bus_bg)
    );

    // register block steers the renderer next to it
    player_regs u_player_regs (
        .clk     (clk),
        .rst     (rst),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp),
        .cfg     (player_cfg)
    );

    draw_player u_draw_player (
        .clk  (clk),
        .rst  (rst),
        .vin  (bus_bg),
        .cfg  (player_cfg),
        .vout (vga_out)
    );

endmodule

// File: rtl/draw_player.sv
`timescale 1ns/1ns

`include "game_params.svh"

module draw_player (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::vga_bus_t    vin,
    input  game_pkg::player_cfg_t cfg,
    output game_pkg::vga_bus_t    vout
);

    // sprite columns relative to xpos
    localparam int PAW_L_FIRST = 1;
    localparam int PAW_L_LAST  = 14;
    localparam int PAW_R_FIRST = 26;
    localparam int PAW_R_LAST  = 39;
    localparam int EAR_LAST    = 420;
    localparam int LEG_FIRST   = 481;
    localparam int IDLE_BODY_LAST = 480;
    localparam int SIDE_BODY_W = 23;
    localparam int SIDE_EYE_W  = 4;
    localparam int SIDE_EYE_H  = 9;

    game_pkg::vga_bus_t    s1_bus;
    game_pkg::vga_bus_t    s2_bus;
    game_pkg::vga_bus_t    vout_nxt;
    game_pkg::player_state_t s1_state;

    logic signed [13:0] rel_x;
    logic signed [13:0] rel_y;
    logic signed [13:0] s1_col;
    logic signed [13:0] s1_row;
    logic signed [13:0] s1_dx_l;
    logic signed [13:0] s1_dx_r;
    logic signed [13:0] s1_dy;
    logic [11:0]        s1_body_rgb;
    logic [11:0]        s1_eye_rgb;

    logic               body_hit;
    logic               eye_rect;
    logic               eye_hit;
    logic [27:0]        s2_dist_l;
    logic [27:0]        s2_dist_r;
    logic               s2_round;
    logic               s2_eye_rect;
    logic               s2_body;
    logic [11:0]        s2_body_rgb;
    logic [11:0]        s2_eye_rgb;

    function automatic logic in_span(input logic signed [13:0] v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    // jumping moves the sprite up, so ypos adds to the row
    assign rel_x = $signed({2'b00, vin.hcount}) - $signed({2'b00, cfg.xpos});
    assign rel_y = $signed({2'b00, vin.vcount}) + $signed({{2{cfg.ypos[11]}}, cfg.ypos});

    always_comb begin
        body_hit = 1'b0;
        eye_rect = 1'b0;
        case (s1_state)
            game_pkg::IDLE: begin
                body_hit = (in_span(s1_col, PAW_L_FIRST, PAW_R_LAST)
                            && in_span(s1_row, EAR_LAST + 1, IDLE_BODY_LAST))
                        || ((in_span(s1_col, PAW_L_FIRST, PAW_L_LAST)
                            || in_span(s1_col, PAW_R_FIRST, PAW_R_LAST))
                            && (in_span(s1_row, `SPR_TOP, EAR_LAST)
                            || in_span(s1_row, LEG_FIRST, `SPR_BOTTOM - 1)));
            end
            game_pkg::RIGHT: begin
                body_hit = in_span(s1_col, 1, 1 + SIDE_BODY_W)
                        && in_span(s1_row, `SPR_TOP + 1, `SPR_BOTTOM - 1);
                eye_rect = in_span(s1_col, 25, 25 + SIDE_EYE_W)
                        && in_span(s1_row, `EYE_ROW - SIDE_EYE_H, `EYE_ROW + SIDE_EYE_H);
            end
            game_pkg::LEFT: begin
                body_hit = in_span(s1_col, 6, 6 + SIDE_BODY_W)
                        && in_span(s1_row, `SPR_TOP + 1, `SPR_BOTTOM - 1);
                eye_rect = in_span(s1_col, 0, SIDE_EYE_W)
                        && in_span(s1_row, `EYE_ROW - SIDE_EYE_H, `EYE_ROW + SIDE_EYE_H);
            end
            default: ;
        endcase
    end

    // eyes win over body, blanking passes rgb through
    always_comb begin
        eye_hit  = s2_round ? ((s2_dist_l <= `EYE_R2) || (s2_dist_r <= `EYE_R2)) : s2_eye_rect;
        vout_nxt = s2_bus;
        if (!(s2_bus.hblnk || s2_bus.vblnk)) begin
            if (eye_hit) begin
                vout_nxt.rgb = s2_eye_rgb;
            end else if (s2_body) begin
                vout_nxt.rgb = s2_body_rgb;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_bus <= '0;
            s2_bus <= '0;
            vout   <= '0;
        end else begin
            s1_bus <= vin;
            s2_bus <= s1_bus;
            vout   <= vout_nxt;
        end
    end

    always_ff @(posedge clk) begin
        s1_col      <= rel_x;
        s1_row      <= rel_y;
        s1_dx_l     <= 14'(rel_x - `EYE_L_COL);
        s1_dx_r     <= 14'(rel_x - `EYE_R_COL);
        s1_dy       <= 14'(rel_y - `EYE_ROW);
        s1_state    <= cfg.state;
        s1_body_rgb <= cfg.body_rgb;
        s1_eye_rgb  <= cfg.eye_rgb;

        s2_dist_l   <= s1_dx_l * s1_dx_l + s1_dy * s1_dy;
        s2_dist_r   <= s1_dx_r * s1_dx_r + s1_dy * s1_dy;
        s2_round    <= (s1_state == game_pkg::IDLE);
        s2_eye_rect <= eye_rect;
        s2_body     <= body_hit;
        s2_body_rgb <= s1_body_rgb;
        s2_eye_rgb  <= s1_eye_rgb;
    end

endmodule

// File: rtl/player_regs.sv
`timescale 1ns/1ns

`include "game_params.svh"

module player_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::axil_req_t   axi_req,
    output game_pkg::axil_rsp_t   axi_rsp,
    output game_pkg::player_cfg_t cfg
);

    localparam logic [11:0] XPOS_RST = 12'd300;

    logic        wr_ready;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        rd_ready;
    logic        rvalid_q;
    logic [1:0]  rresp_q;
    logic [31:0] rdata_q;

    logic        wr_fire;
    logic        rd_fire;
    logic        wr_err;
    logic        rd_err;
    logic [31:0] rd_word;

    assign wr_fire = wr_ready && axi_req.awvalid && axi_req.wvalid;
    assign rd_fire = rd_ready && axi_req.arvalid;

    // state 3 and unaligned addresses are rejected
    always_comb begin
        case (axi_req.awaddr)
            `REG_STATE:                       wr_err = (axi_req.wdata[1:0] == 2'd3);
            `REG_XPOS, `REG_YPOS, `REG_COLOR: wr_err = 1'b0;
            default:                          wr_err = 1'b1;
        endcase
    end

    always_comb begin
        rd_err  = 1'b0;
        rd_word = '0;
        case (axi_req.araddr)
            `REG_STATE: rd_word = {30'd0, cfg.state};
            `REG_XPOS:  rd_word = {20'd0, cfg.xpos};
            `REG_YPOS:  rd_word = {20'd0, cfg.ypos};
            `REG_COLOR: rd_word = {8'd0, cfg.eye_rgb, cfg.body_rgb};
            default:    rd_err  = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.state    <= game_pkg::IDLE;
            cfg.xpos     <= XPOS_RST;
            cfg.ypos     <= '0;
            cfg.body_rgb <= `BODY_RGB_RST;
            cfg.eye_rgb  <= `EYE_RGB_RST;
        end else if (wr_fire && !wr_err) begin
            case (axi_req.awaddr)
                `REG_STATE: cfg.state <= game_pkg::player_state_t'(axi_req.wdata[1:0]);
                `REG_XPOS:  cfg.xpos  <= axi_req.wdata[11:0];
                `REG_YPOS:  cfg.ypos  <= axi_req.wdata[11:0];
                `REG_COLOR: begin
                    cfg.body_rgb <= axi_req.wdata[11:0];
                    cfg.eye_rgb  <= axi_req.wdata[23:12];
                end
                default: ;
            endcase
        end
    end

    // handshake control, ready pulses one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready <= 1'b0;
            bvalid_q <= 1'b0;
            rd_ready <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            wr_ready <= axi_req.awvalid && axi_req.wvalid && !bvalid_q && !wr_ready;
            rd_ready <= axi_req.arvalid && !rvalid_q && !rd_ready;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (axi_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (axi_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // response payload, held until taken
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp_q <= wr_err ? `RESP_SLVERR : `RESP_OKAY;
        end
        if (rd_fire) begin
            rdata_q <= rd_word;
            rresp_q <= rd_err ? `RESP_SLVERR : `RESP_OKAY;
        end
    end

    assign axi_rsp.awready = wr_ready;
    assign axi_rsp.wready  = wr_ready;
    assign axi_rsp.bresp   = bresp_q;
    assign axi_rsp.bvalid  = bvalid_q;
    assign axi_rsp.arready = rd_ready;
    assign axi_rsp.rdata   = rdata_q;
    assign axi_rsp.rresp   = rresp_q;
    assign axi_rsp.rvalid  = rvalid_q;

endmodule

// File: rtl/draw_background.sv
`timescale 1ns/1ns

`include "game_params.svh"

module draw_background (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::vga_bus_t vin,
    output game_pkg::vga_bus_t vout
);

    game_pkg::vga_bus_t vout_nxt;

    always_comb begin
        vout_nxt = vin;
        if (vin.hblnk || vin.vblnk) begin
            vout_nxt.rgb = 12'h000;
        end else if (vin.vcount < `GROUND_Y) begin
            vout_nxt.rgb = `SKY_RGB;
        end else begin
            // ground runs to the bottom of the screen
            vout_nxt.rgb = `GROUND_RGB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vout <= '0;
        end else begin
            vout <= vout_nxt;
        end
    end

endmodule

// File: rtl/vga_timing.sv
`timescale 1ns/1ns

`include "game_params.svh"

module vga_timing (
    input  logic               clk,
    input  logic               rst,
    output game_pkg::vga_bus_t vout
);

    localparam int H_SYNC_START = `H_ACTIVE + `H_FP;
    localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FP;
    localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;

    logic [11:0]        hcount_nxt;
    logic [11:0]        vcount_nxt;
    game_pkg::vga_bus_t vout_nxt;

    // counters wrap at the frame totals
    always_comb begin
        if (vout.hcount == 12'(`H_TOTAL - 1)) begin
            hcount_nxt = '0;
            if (vout.vcount == 12'(`V_TOTAL - 1)) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vout.vcount + 12'd1;
            end
        end else begin
            hcount_nxt = vout.hcount + 12'd1;
            vcount_nxt = vout.vcount;
        end
    end

    // decode from the next counts so every field is aligned
    always_comb begin
        vout_nxt.hcount = hcount_nxt;
        vout_nxt.vcount = vcount_nxt;
        vout_nxt.hsync  = (hcount_nxt >= H_SYNC_START) && (hcount_nxt < H_SYNC_END);
        vout_nxt.vsync  = (vcount_nxt >= V_SYNC_START) && (vcount_nxt < V_SYNC_END);
        vout_nxt.hblnk  = (hcount_nxt >= `H_ACTIVE);
        vout_nxt.vblnk  = (vcount_nxt >= `V_ACTIVE);
        vout_nxt.rgb    = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vout <= '0;
        end else begin
            vout <= vout_nxt;
        end
    end

endmodule

// File: rtl/game_pkg.sv
package game_pkg;

    // pixel stream between drawing stages
    typedef struct packed {
        logic [11:0] hcount;
        logic [11:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_bus_t;

    // value 3 is illegal
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RIGHT = 2'd1,
        LEFT  = 2'd2
    } player_state_t;

    typedef struct packed {
        player_state_t state;
        logic [11:0]   xpos;
        logic [11:0]   ypos;
        logic [11:0]   body_rgb;
        logic [11:0]   eye_rgb;
    } player_cfg_t;

    // master side of the AXI4-Lite port
    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // slave side
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

// File: include/game_params.svh
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// 640x480 at one pixel per clock
`define H_ACTIVE 640
`define H_FP     16
`define H_SYNC   96
`define H_TOTAL  800

`define V_ACTIVE 480
`define V_FP     10
`define V_SYNC   2
`define V_TOTAL  525

// first row of the ground band
`define GROUND_Y 400

// sprite rows before the jump offset
`define SPR_TOP    410
`define SPR_BOTTOM 500

// round eyes of the idle sprite
`define EYE_R2    30
`define EYE_ROW   440
`define EYE_L_COL 10
`define EYE_R_COL 27

// register map
`define REG_STATE 4'h0
`define REG_XPOS  4'h4
`define REG_YPOS  4'h8
`define REG_COLOR 4'hC

`define SKY_RGB      12'h48F
`define GROUND_RGB   12'h360
`define BODY_RGB_RST 12'hF00
`define EYE_RGB_RST  12'h0FF

`define RESP_OKAY   2'd0
`define RESP_SLVERR 2'd2

`endif
